//--- filelist.f
rtl/pe_pkg.sv
rtl/n_delay.sv
rtl/proc_element.sv
rtl/acc_control.sv
rtl/skid_buffer.sv
rtl/proc_engine.sv
dv/proc_engine_chk.sv
dv/proc_engine_tb.sv

//--- dv/proc_engine_tb.sv
/* Testbench for the processing engine: clock and reset, random runs
   with valid gaps and ready back-pressure, a reference model of the
   sum grid, result checks and a watchdog. */
module proc_engine_tb;
  import pe_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int TOTAL_RUNS = 5 * 20 + 6 + 10;
  localparam int MAX_BEATS  = TOTAL_RUNS * 5;  // longest run is 5 beats.

  logic       clk;
  logic       i_arst_n;
  logic       o_s_ready;
  logic       i_s_valid;
  logic       i_s_last;
  pixels_t    i_s_pixels;
  weights_t   i_s_weights;
  tuser_st    i_s_user;
  logic       i_m_ready;
  logic       o_m_valid;
  logic       o_m_last;
  acc_grid_t  o_m_data;
  tuser_st    o_m_user;

  integer     seed = 329;
  int         ready_pct = 100;
  int         errors = 0;
  int         checks = 0;
  int         results = 0;
  int         tests = 0;
  acc_grid_t  run_grid;
  out_beat_st exp_q[$];

  proc_engine u_dut (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .o_s_ready   (o_s_ready),
    .i_s_valid   (i_s_valid),
    .i_s_last    (i_s_last),
    .i_s_pixels  (i_s_pixels),
    .i_s_weights (i_s_weights),
    .i_s_user    (i_s_user),
    .i_m_ready   (i_m_ready),
    .o_m_valid   (o_m_valid),
    .o_m_last    (o_m_last),
    .o_m_data    (o_m_data),
    .o_m_user    (o_m_user)
  );

  bind proc_engine proc_engine_chk u_chk (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_s_valid (i_s_valid),
    .i_s_ready (o_s_ready),
    .i_m_ready (i_m_ready),
    .i_m_valid (o_m_valid),
    .i_m_data  (o_m_data),
    .i_m_user  (o_m_user),
    .i_m_last  (o_m_last)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  task automatic check_value(input logic [$bits(acc_grid_t)-1:0] got,
                             input logic [$bits(acc_grid_t)-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // reference sum of products, restarted by is_first.
  task automatic model_accept();
    logic signed [WORD_WIDTH-1:0] p;
    logic signed [WORD_WIDTH-1:0] w;
    if (i_s_user.is_first) run_grid = '0;
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) begin
        p = i_s_pixels[r];
        w = i_s_weights[c];
        run_grid[c][r] = run_grid[c][r] + p * w;
      end
    end
    if (i_s_user.is_cin_last) exp_q.push_back('{data: run_grid, user: i_s_user, last: i_s_last});
  endtask

  task automatic model_compare();
    out_beat_st exp;
    if (exp_q.size() == 0) begin
      errors++;
      $display("a result came out at time %0t while no run was pending", $time);
    end else begin
      exp = exp_q.pop_front();
      check_value(o_m_data, exp.data, "sum grid");
      check_value(o_m_user, exp.user, "user");
      check_value(o_m_last, exp.last, "last");
      results++;
    end
  endtask

  // mid-cycle sampling, all handshake signals are settled here.
  always @(negedge clk) begin
    if (i_arst_n) begin
      if (i_s_valid && o_s_ready) model_accept();
      if (o_m_valid && i_m_ready) model_compare();
    end
  end

  always @(posedge clk) begin
    #1;
    i_m_ready = (rand_pct() < ready_pct);
  end

  task automatic send_run(input int len, input int valid_pct);
    logic taken;
    for (int b = 0; b < len; b++) begin
      while (rand_pct() >= valid_pct) begin
        i_s_valid = 1'b0;  // gap.
        @(posedge clk);
        #1;
      end
      i_s_valid = 1'b1;
      i_s_last  = $random(seed);
      foreach (i_s_pixels[r]) i_s_pixels[r] = $random(seed);
      foreach (i_s_weights[c]) i_s_weights[c] = $random(seed);
      i_s_user = '{is_first: (b == 0), is_cin_last: (b == len - 1), tag: $random(seed)};
      do begin
        taken = o_s_ready;
        @(posedge clk);
        #1;
      end while (!taken);
    end
    i_s_valid = 1'b0;
  endtask

  task automatic apply_reset();
    i_s_valid = 1'b0;
    i_arst_n  = 1'b0;
    exp_q.delete();  // in-flight results are dropped.
    repeat (10) begin
      @(posedge clk);
      #1;
      check_value(o_m_valid, 1'b0, "o_m_valid during reset");
    end
    i_arst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value(o_m_valid, 1'b0, "o_m_valid after reset");
  endtask

  task automatic run_test(input string name, input int n_runs, input int max_len,
                          input int valid_pct, input int r_pct);
    int err0;
    int res0;
    err0      = errors;
    res0      = results;
    ready_pct = r_pct;
    for (int i = 0; i < n_runs; i++) send_run(1 + rand_pct() % max_len, valid_pct);
    while (exp_q.size() != 0) @(posedge clk);
    repeat (8) @(posedge clk);  // nothing extra may follow.
    #1;
    tests++;
    $display("test %-12s %0d results, %0d errors", name, results - res0, errors - err0);
  endtask

  initial begin
    #(MAX_BEATS * 10 * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d time units",
             MAX_BEATS * 10 * CLK_PERIOD);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    i_arst_n    = 1'b1;
    i_s_valid   = 1'b0;
    i_s_last    = 1'b0;
    i_s_pixels  = '0;
    i_s_weights = '0;
    i_s_user    = '0;
    i_m_ready   = 1'b0;
    #1;
    apply_reset();
    run_test("single", 20, 1, 100, 100);
    run_test("multi", 20, 5, 100, 100);
    run_test("backpressure", 20, 5, 100, 50);
    run_test("valid_gaps", 20, 5, 60, 100);
    run_test("mixed", 20, 5, 60, 60);
    ready_pct = 40;
    for (int i = 0; i < 6; i++) send_run(1 + rand_pct() % 5, 80);
    apply_reset();
    run_test("after_reset", 10, 5, 100, 100);
    errors = errors + u_dut.u_chk.fail_count;
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results never came out", exp_q.size());
    end
    $display("tests %0d, checks %0d, results %0d, errors %0d", tests, checks, results, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- dv/proc_engine_chk.sv
/* Assertions on the engine's streams: quiet output in reset,
   stable output under stall, input refused only behind a stalled output. */
module proc_engine_chk (
  input logic              clk,
  input logic              i_arst_n,
  input logic              i_s_valid,
  input logic              i_s_ready,
  input logic              i_m_ready,
  input logic              i_m_valid,
  input pe_pkg::acc_grid_t i_m_data,
  input pe_pkg::tuser_st   i_m_user,
  input logic              i_m_last
);

  int fail_count = 0;

  a_reset_quiet: assert property (@(posedge clk) !i_arst_n |-> !i_m_valid)
    else begin
      fail_count++;
      $error("output valid high while reset is held");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data) && $stable(i_m_user)
      && $stable(i_m_last))
    else begin
      fail_count++;
      $error("stalled output beat changed");
    end

  // a refused input beat waits behind a stalled output.
  a_refuse_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_s_valid && !i_s_ready |-> i_m_valid && $past(!i_m_ready))
    else begin
      fail_count++;
      $error("input beat refused while the output was not stalled");
    end

endmodule

//--- rtl/proc_engine.sv
/* Processing engine top: accumulator control, a COLS x ROWS
   grid of multiply-accumulate elements and the output skid
   buffer, all advancing on one enable. */
module proc_engine (
  input  logic              clk,
  input  logic              i_arst_n,

  output logic              o_s_ready,
  input  logic              i_s_valid,
  input  logic              i_s_last,
  input  pe_pkg::pixels_t   i_s_pixels,
  input  pe_pkg::weights_t  i_s_weights,
  input  pe_pkg::tuser_st   i_s_user,

  input  logic              i_m_ready,
  output logic              o_m_valid,
  output logic              o_m_last,
  output pe_pkg::acc_grid_t o_m_data,
  output pe_pkg::tuser_st   o_m_user
);
  import pe_pkg::*;

  logic            en;
  logic [COLS-1:0] bypass;
  logic [COLS-1:0] clken_acc;
  logic            res_valid;
  logic            res_last;
  tuser_st         res_user;
  acc_grid_t       sum_grid;
  out_beat_st      res_beat;
  out_beat_st      out_beat;

  assign o_s_ready = en;  // input taken whenever the pipe moves.

  acc_control u_acc_control (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_en        (en),
    .i_valid     (i_s_valid),
    .i_last      (i_s_last),
    .i_user      (i_s_user),
    .o_bypass    (bypass),
    .o_clken_acc (clken_acc),
    .o_valid     (res_valid),
    .o_last      (res_last),
    .o_user      (res_user)
  );

  for (genvar c = 0; c < COLS; c++) begin : g_col
    for (genvar r = 0; r < ROWS; r++) begin : g_row
      proc_element u_pe (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_en        (en),
        .i_pixel     (i_s_pixels[r]),
        .i_weight    (i_s_weights[c]),
        .i_bypass    (bypass[c]),
        .i_clken_acc (clken_acc[c]),
        .o_sum       (sum_grid[c][r])
      );
    end
  end

  assign res_beat = '{data: sum_grid, user: res_user, last: res_last};

  // ready of the skid buffer is the enable of every stage.
  skid_buffer u_skid_buffer (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .o_s_ready (en),
    .i_s_valid (res_valid),
    .i_s_beat  (res_beat),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_beat  (out_beat)
  );

  assign o_m_data = out_beat.data;
  assign o_m_user = out_beat.user;
  assign o_m_last = out_beat.last;

endmodule

//--- rtl/skid_buffer.sv
/* Two-entry valid/ready register stage: an output
   register plus one spare, with a registered ready. */
module skid_buffer (
  input  logic               clk,
  input  logic               i_arst_n,
  output logic               o_s_ready,
  input  logic               i_s_valid,
  input  pe_pkg::out_beat_st i_s_beat,
  input  logic               i_m_ready,
  output logic               o_m_valid,
  output pe_pkg::out_beat_st o_m_beat
);
  import pe_pkg::*;

  logic       spare_valid;
  out_beat_st spare_q;
  logic       m_free;

  assign m_free    = ~o_m_valid | i_m_ready;  // output register can take a beat.
  assign o_s_ready = ~spare_valid;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_m_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else if (m_free) begin
      o_m_valid   <= spare_valid | i_s_valid;
      spare_valid <= 1'b0;  // spare drains first.
    end else if (i_s_valid && o_s_ready) begin
      spare_valid <= 1'b1;  // stalled, park the beat.
    end
  end

  always_ff @(posedge clk) begin
    if (m_free) begin
      if (spare_valid) begin
        o_m_beat <= spare_q;
      end else begin
        o_m_beat <= i_s_beat;
      end
    end else if (i_s_valid && o_s_ready) begin
      spare_q <= i_s_beat;
    end
  end

endmodule

//--- rtl/acc_control.sv
/* Accumulator control: carries valid, last and user
   alongside the multiplier and accumulator stages and
   derives per-column bypass and accumulate enables. */
module acc_control (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic                    i_en,
  input  logic                    i_valid,
  input  logic                    i_last,
  input  pe_pkg::tuser_st         i_user,
  output logic [pe_pkg::COLS-1:0] o_bypass,
  output logic [pe_pkg::COLS-1:0] o_clken_acc,
  output logic                    o_valid,
  output logic                    o_last,
  output pe_pkg::tuser_st         o_user
);
  import pe_pkg::*;

  logic [$bits(tuser_st)+1:0] mul_word;
  logic [$bits(tuser_st)+1:0] res_word;
  logic                       mul_valid;
  logic                       mul_last;
  tuser_st                    mul_user;
  logic                       res_valid_next;

  n_delay #(
    .N     (LATENCY_MULTIPLIER),
    .WIDTH ($bits(tuser_st) + 2)
  ) u_mul_delay (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clken  (i_en),
    .i_data   ({i_valid, i_last, i_user}),
    .o_data   (mul_word)
  );

  assign {mul_valid, mul_last, mul_user} = mul_word;

  // all columns start and step together here.
  assign o_bypass    = {COLS{mul_user.is_first}};
  assign o_clken_acc = {COLS{i_en & mul_valid}};

  assign res_valid_next = mul_valid & mul_user.is_cin_last;  // only closing beats.

  n_delay #(
    .N     (LATENCY_ACCUMULATOR),
    .WIDTH ($bits(tuser_st) + 2)
  ) u_acc_delay (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_clken  (i_en),
    .i_data   ({res_valid_next, mul_last, mul_user}),
    .o_data   (res_word)
  );

  assign {o_valid, o_last, o_user} = res_word;

endmodule

//--- rtl/proc_element.sv
/* Multiply-accumulate element: pipelined signed
   multiplier followed by a loadable accumulator. */
module proc_element (
  input  logic          clk,
  input  logic          i_arst_n,
  input  logic          i_en,
  input  pe_pkg::word_t i_pixel,
  input  pe_pkg::word_t i_weight,
  input  logic          i_bypass,
  input  logic          i_clken_acc,
  output pe_pkg::acc_t  o_sum
);
  import pe_pkg::*;

  logic signed [2*WORD_WIDTH-1:0] mul_q [LATENCY_MULTIPLIER];
  acc_t                           product;

  // multiplier pipeline, stalls with the whole engine.
  always_ff @(posedge clk) begin
    if (i_en) begin
      mul_q[0] <= i_pixel * i_weight;
      for (int i = 1; i < LATENCY_MULTIPLIER; i++) begin
        mul_q[i] <= mul_q[i-1];
      end
    end
  end

  assign product = acc_t'(mul_q[LATENCY_MULTIPLIER-1]);  // sign extended.

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sum <= '0;
    end else if (i_clken_acc) begin
      if (i_bypass) begin
        o_sum <= product;  // first beat of a run.
      end else begin
        o_sum <= o_sum + product;
      end
    end
  end

endmodule

//--- rtl/n_delay.sv
/* Clock-enabled delay line of N registers,
   cleared by reset. */
module n_delay #(
  parameter int N     = 1,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_clken,
  input  logic [WIDTH-1:0] i_data,
  output logic [WIDTH-1:0] o_data
);

  logic [N-1:0][WIDTH-1:0] stage_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stage_q <= '0;
    end else if (i_clken) begin
      stage_q[0] <= i_data;
      for (int i = 1; i < N; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_data = stage_q[N-1];  // oldest stage.

endmodule

//--- rtl/pe_pkg.sv
/* Sizes, pipeline latencies and shared stream types
   of the processing engine: user word, pixel and weight
   beats, the sum grid and the stored output beat. */
package pe_pkg;

  localparam int ROWS                = 2;
  localparam int COLS                = 3;
  localparam int WORD_WIDTH          = 8;
  localparam int WORD_WIDTH_ACC      = 24;
  localparam int LATENCY_MULTIPLIER  = 2;
  localparam int LATENCY_ACCUMULATOR = 1;
  localparam int TAG_WIDTH           = 4;

  typedef logic signed [WORD_WIDTH-1:0]     word_t;
  typedef logic signed [WORD_WIDTH_ACC-1:0] acc_t;

  typedef struct packed {
    logic                 is_first;     // opens a run.
    logic                 is_cin_last;  // closes a run.
    logic [TAG_WIDTH-1:0] tag;
  } tuser_st;

  typedef word_t [ROWS-1:0] pixels_t;
  typedef word_t [COLS-1:0] weights_t;

  // indexed [col][row], like the element grid.
  typedef acc_t [COLS-1:0][ROWS-1:0] acc_grid_t;

  typedef struct packed {
    acc_grid_t data;
    tuser_st   user;
    logic      last;
  } out_beat_st;

endpackage
